/* aes_kv_wrap.f */
common/aes_kv_pkg.sv
kv_intercept/kv_intercept_ctrl.sv
kv_intercept/kv_chunk_buffer.sv
design/edn_req_arbiter.sv
design/aes_kv_wrap.sv
+incdir+tb
tb/tb_aes_kv_wrap.sv

/* tb/tb_aes_kv_checks.svh */
////////////////////////////////////////////////////////////
// AES key-vault wrapper testbench checks
// Concurrent assertions comparing the DUT with the model
////////////////////////////////////////////////////////////

`ifndef TB_AES_KV_CHECKS_SVH
`define TB_AES_KV_CHECKS_SVH

  ////////////////////////////////////////////////////////////
  // Key-vault buffer and concealment
  ////////////////////////////////////////////////////////////

  kv_data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kv_data == m_kv)
    else report_mismatch("kv_data_o", $sampled(m_kv), $sampled(kv_data));

  kv_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kv_data_valid == m_valid)
    else report_mismatch("kv_data_valid_o", $sampled(m_valid), $sampled(kv_data_valid));

  data_out_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_out == exp_data_out)
    else report_mismatch("data_out_o", $sampled(exp_data_out), $sampled(data_out));

  output_lost_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    output_lost == m_lost)
    else report_mismatch("output_lost_o", $sampled(m_lost), $sampled(output_lost));

  // Valid only rises on the cycle after an idle strobe
  valid_after_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(kv_data_valid) |-> $past(core_idle))
    else begin
      $display("Error: time %0t, kv_data_valid_o rose without a preceding idle", $time);
      end_in_failure();
    end

  ////////////////////////////////////////////////////////////
  // Entropy arbitration
  ////////////////////////////////////////////////////////////

  edn_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req == exp_edn_req)
    else report_mismatch("edn_req_o", $sampled(exp_edn_req), $sampled(edn_req));

  clearing_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clearing_ack == exp_clr_ack)
    else report_mismatch("clearing_ack_o", $sampled(exp_clr_ack), $sampled(clearing_ack));

  masking_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    masking_ack == exp_msk_ack)
    else report_mismatch("masking_ack_o", $sampled(exp_msk_ack), $sampled(masking_ack));

  entropy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy == edn_bus)
    else report_mismatch("entropy_o", $sampled(edn_bus), $sampled(entropy));

  ack_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clearing_ack && masking_ack))
    else begin
      $display("Error: time %0t, both PRNGs were acknowledged together", $time);
      end_in_failure();
    end

`endif

/* tb/tb_aes_kv_wrap.sv */
////////////////////////////////////////////////////////////
// AES key-vault wrapper testbench
// Drives key-vault operations, clears and EDN traffic and
// checks the DUT against a reference model
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_aes_kv_wrap;

  localparam int unsigned NumChunks     = aes_kv_pkg::NumChunks;
  localparam int unsigned KvWidth       = NumChunks * aes_kv_pkg::BlockWidth;
  localparam int unsigned EntWidth      = aes_kv_pkg::EntropyWidth;
  // Upper estimate of all directed and random sequences
  localparam int unsigned SeqCycles     = 500;
  localparam int unsigned TimeoutCycles = 4 * SeqCycles;
  localparam logic [31:0] LfsrSeed      = 32'h05fd_edae;

  logic                  clk_i;
  logic                  rst_ni;
  aes_kv_pkg::core_out_t core_out;
  logic                  core_idle;
  logic                  data_in_we;
  aes_kv_pkg::kv_ctrl_t  kv_ctrl;
  aes_kv_pkg::block_t    data_out;
  logic                  output_lost;
  logic [KvWidth-1:0]    kv_data;
  logic                  kv_data_valid;
  logic                  clearing_req;
  logic                  masking_req;
  logic                  clearing_ack;
  logic                  masking_ack;
  logic                  edn_req;
  logic                  edn_ack;
  logic [EntWidth-1:0]   edn_bus;
  logic [EntWidth-1:0]   entropy;

  // Reference model state
  logic                   m_intercept;
  logic                   m_mask;
  logic                   m_lost;
  logic                   m_valid;
  logic                   m_pending;
  aes_kv_pkg::chunk_idx_t m_cnt;
  logic [KvWidth-1:0]     m_kv;

  // Model next state and expected outputs
  logic                   n_intercept;
  logic                   n_mask;
  logic                   n_lost;
  logic                   n_valid;
  logic                   n_pending;
  aes_kv_pkg::chunk_idx_t n_cnt;
  logic [KvWidth-1:0]     n_kv;
  aes_kv_pkg::chunk_idx_t m_thr;
  logic                   m_end;
  aes_kv_pkg::block_t     exp_data_out;
  logic                   exp_edn_req;
  logic                   exp_clr_ack;
  logic                   exp_msk_ack;

  logic [31:0] lfsr_state = LfsrSeed;
  int unsigned cycle_cnt  = 0;

  // Scenario reach flags
  logic seen_valid   = 1'b0;
  logic seen_lost    = 1'b0;
  logic seen_pass    = 1'b0;
  logic seen_clr_ack = 1'b0;
  logic seen_msk_ack = 1'b0;
  logic seen_held    = 1'b0;

  aes_kv_wrap #(
    .NumChunks (NumChunks)
  ) UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .core_out_i      (core_out),
    .core_idle_i     (core_idle),
    .data_in_we_i    (data_in_we),
    .kv_ctrl_i       (kv_ctrl),
    .data_out_o      (data_out),
    .output_lost_o   (output_lost),
    .kv_data_o       (kv_data),
    .kv_data_valid_o (kv_data_valid),
    .clearing_req_i  (clearing_req),
    .masking_req_i   (masking_req),
    .clearing_ack_o  (clearing_ack),
    .masking_ack_o   (masking_ack),
    .edn_req_o       (edn_req),
    .edn_ack_i       (edn_ack),
    .edn_bus_i       (edn_bus),
    .entropy_o       (entropy)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Last chunk index is key bytes over 16, minus one
    m_thr       = aes_kv_pkg::chunk_idx_t'((kv_ctrl.key_size >> 4) - 7'd1);
    m_end       = m_intercept && core_idle && (m_cnt == m_thr);
    n_intercept = m_intercept;
    n_mask      = m_mask;
    n_lost      = m_lost;
    n_cnt       = m_cnt;
    n_kv        = m_kv;
    n_valid     = m_valid;
    if (data_in_we && (m_cnt == '0)) begin
      n_intercept = kv_ctrl.kv_en;
      n_mask      = !kv_ctrl.kv_en && !kv_ctrl.block_reg_output;
      n_lost      = 1'b0;
    end else if (m_end) begin
      n_intercept = 1'b0;
      n_mask      = 1'b1;
    end
    if (core_out.valid && kv_ctrl.block_reg_output) begin
      n_lost = 1'b1;
    end
    if (m_intercept && core_out.valid && (m_cnt != m_thr)) begin
      n_cnt = m_cnt + 1'b1;
    end
    if (m_end) begin
      n_cnt = '0;
    end
    if (kv_ctrl.clear_secrets || kv_ctrl.data_out_clear) begin
      n_kv    = '0;
      n_valid = 1'b0;
    end else begin
      if (kv_ctrl.kv_write_done && !m_end) begin
        n_kv    = '0;
        n_valid = 1'b0;
      end
      if (m_intercept && core_out.valid) begin
        n_kv[m_cnt*aes_kv_pkg::BlockWidth +: aes_kv_pkg::BlockWidth] = core_out.data;
      end
      if (m_end) begin
        n_valid = 1'b1;
      end
    end
    // EDN request stays up from first request until an ack
    exp_edn_req  = clearing_req || masking_req || m_pending;
    n_pending    = exp_edn_req && !edn_ack;
    exp_clr_ack  = clearing_req && edn_ack;
    exp_msk_ack  = masking_req && !clearing_req && edn_ack;
    exp_data_out = m_mask ? core_out.data : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_intercept <= 1'b0;
      m_mask      <= 1'b1;
      m_lost      <= 1'b0;
      m_valid     <= 1'b0;
      m_pending   <= 1'b0;
      m_cnt       <= '0;
      m_kv        <= '0;
    end else begin
      m_intercept <= n_intercept;
      m_mask      <= n_mask;
      m_lost      <= n_lost;
      m_valid     <= n_valid;
      m_pending   <= n_pending;
      m_cnt       <= n_cnt;
      m_kv        <= n_kv;
    end
  end

  // Record which behaviors the stimulus reached
  always @(posedge clk_i) begin
    if (rst_ni) begin
      seen_valid   <= seen_valid | kv_data_valid;
      seen_lost    <= seen_lost | output_lost;
      seen_pass    <= seen_pass | (m_mask && core_out.valid && (data_out != '0));
      seen_clr_ack <= seen_clr_ack | (clearing_ack && masking_req);
      seen_msk_ack <= seen_msk_ack | masking_ack;
      seen_held    <= seen_held | (edn_req && !clearing_req && !masking_req);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      end_in_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [127:0] bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits       = {bits[126:0], lfsr_state[0]};
    end
  endtask

  task automatic end_in_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [511:0] expected,
                                 input logic [511:0] actual);
    $display("Error: time %0t, %s expected %0h, actual %0h", $time, name, expected, actual);
    end_in_failure();
  endtask

  task automatic set_ctrl(input logic kv_en, input logic block, input int unsigned key_size);
    @(posedge clk_i);
    kv_ctrl.kv_en            <= kv_en;
    kv_ctrl.block_reg_output <= block;
    kv_ctrl.key_size         <= aes_kv_pkg::key_size_t'(key_size);
  endtask

  // First data-in word write
  task automatic arm_operation();
    @(posedge clk_i);
    data_in_we <= 1'b1;
    @(posedge clk_i);
    data_in_we <= 1'b0;
  endtask

  task automatic send_beats(input int unsigned count);
    logic [127:0] bits;
    for (int unsigned i = 0; i < count; i++) begin
      take_bits(128, bits);
      @(posedge clk_i);
      core_out.valid <= 1'b1;
      core_out.data  <= bits;
      @(posedge clk_i);
      core_out.valid <= 1'b0;
    end
  endtask

  // Idle strobe, optionally with a write-done or secrets clear
  task automatic drive_idle(input logic with_done, input logic with_secrets);
    @(posedge clk_i);
    core_idle             <= 1'b1;
    kv_ctrl.kv_write_done <= with_done;
    kv_ctrl.clear_secrets <= with_secrets;
    @(posedge clk_i);
    core_idle             <= 1'b0;
    kv_ctrl.kv_write_done <= 1'b0;
    kv_ctrl.clear_secrets <= 1'b0;
  endtask

  task automatic wait_key_valid();
    @(negedge clk_i);
    while (!kv_data_valid) @(negedge clk_i);
  endtask

  // Kind 0 write-done, 1 clear-secrets, 2 data-out clear
  task automatic clear_key(input int kind);
    @(posedge clk_i);
    kv_ctrl.kv_write_done  <= (kind == 0);
    kv_ctrl.clear_secrets  <= (kind == 1);
    kv_ctrl.data_out_clear <= (kind == 2);
    @(posedge clk_i);
    kv_ctrl.kv_write_done  <= 1'b0;
    kv_ctrl.clear_secrets  <= 1'b0;
    kv_ctrl.data_out_clear <= 1'b0;
    @(negedge clk_i);
    while (kv_data_valid) @(negedge clk_i);
  endtask

  task automatic run_key_op(input int unsigned key_size, input int unsigned beats);
    set_ctrl(1'b1, 1'b0, key_size);
    arm_operation();
    send_beats(beats);
    drive_idle(1'b0, 1'b0);
    wait_key_valid();
  endtask

  task automatic edn_ack_pulse();
    logic [127:0] bits;
    take_bits(EntWidth, bits);
    @(posedge clk_i);
    edn_ack <= 1'b1;
    edn_bus <= bits[EntWidth-1:0];
    @(posedge clk_i);
    edn_ack <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [127:0] bits;
    rst_ni       <= 1'b0;
    core_out     <= '0;
    core_idle    <= 1'b0;
    data_in_we   <= 1'b0;
    kv_ctrl      <= '0;
    clearing_req <= 1'b0;
    masking_req  <= 1'b0;
    edn_ack      <= 1'b0;
    edn_bus      <= '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Key-vault capture at 32 and 64 bytes
    run_key_op(32, 2);
    clear_key(0);
    run_key_op(64, 4);
    clear_key(2);

    // Saturation, chunk 0 ends up with the last of three beats
    run_key_op(16, 3);
    clear_key(1);

    // Secrets clear together with end keeps the key hidden
    set_ctrl(1'b1, 1'b0, 32);
    arm_operation();
    send_beats(2);
    drive_idle(1'b0, 1'b1);
    repeat (3) @(posedge clk_i);

    // Write-done together with end still publishes the key
    set_ctrl(1'b1, 1'b0, 16);
    arm_operation();
    send_beats(1);
    drive_idle(1'b1, 1'b0);
    wait_key_valid();
    clear_key(2);

    // Pass-through, then blocked output
    set_ctrl(1'b0, 1'b0, 16);
    arm_operation();
    send_beats(2);
    drive_idle(1'b0, 1'b0);
    set_ctrl(1'b0, 1'b1, 16);
    arm_operation();
    send_beats(2);
    set_ctrl(1'b0, 1'b0, 16);
    arm_operation();
    send_beats(1);

    // Both PRNGs request, clearing PRNG first
    take_bits(EntWidth, bits);
    @(posedge clk_i);
    clearing_req <= 1'b1;
    masking_req  <= 1'b1;
    edn_bus      <= bits[EntWidth-1:0];
    repeat (2) @(posedge clk_i);
    edn_ack_pulse();
    clearing_req <= 1'b0;
    repeat (2) @(posedge clk_i);
    edn_ack_pulse();
    masking_req <= 1'b0;

    // Request dropped before the ack
    @(posedge clk_i);
    masking_req <= 1'b1;
    @(posedge clk_i);
    masking_req <= 1'b0;
    repeat (3) @(posedge clk_i);
    edn_ack_pulse();

    // Random request, ack and bus patterns
    for (int i = 0; i < 64; i++) begin
      take_bits(EntWidth + 4, bits);
      @(posedge clk_i);
      clearing_req <= bits[EntWidth+3];
      masking_req  <= bits[EntWidth+2];
      edn_ack      <= bits[EntWidth+1] & bits[EntWidth];
      edn_bus      <= bits[EntWidth-1:0];
    end
    @(posedge clk_i);
    clearing_req <= 1'b0;
    masking_req  <= 1'b0;
    edn_ack      <= 1'b0;
    repeat (4) @(posedge clk_i);

    if (seen_valid && seen_lost && seen_pass && seen_clr_ack && seen_msk_ack && seen_held) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Stimulus did not reach every behavior under check");
      end_in_failure();
    end
  end

  `include "tb_aes_kv_checks.svh"

endmodule

`default_nettype wire

/* design/aes_kv_wrap.sv */
////////////////////////////////////////////////////////////
// AES key-vault wrapper
// Intercepts AES output blocks for the key vault and
// arbitrates the two PRNG entropy requests onto one EDN port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module aes_kv_wrap #(
  parameter int unsigned NumChunks = aes_kv_pkg::NumChunks
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  // AES core side
  input  aes_kv_pkg::core_out_t                      core_out_i,
  input  logic                                       core_idle_i,
  input  logic                                       data_in_we_i,

  // Key-vault control and status
  input  aes_kv_pkg::kv_ctrl_t                       kv_ctrl_i,
  output aes_kv_pkg::block_t                         data_out_o,
  output logic                                       output_lost_o,
  output logic [NumChunks*aes_kv_pkg::BlockWidth-1:0] kv_data_o,
  output logic                                       kv_data_valid_o,

  // Entropy requesters
  input  logic                                       clearing_req_i,
  input  logic                                       masking_req_i,
  output logic                                       clearing_ack_o,
  output logic                                       masking_ack_o,

  // EDN port
  output logic                                       edn_req_o,
  input  logic                                       edn_ack_i,
  input  logic [aes_kv_pkg::EntropyWidth-1:0]        edn_bus_i,
  output logic [aes_kv_pkg::EntropyWidth-1:0]        entropy_o
);

  logic                  kv_capture;
  aes_kv_pkg::chunk_idx_t kv_capture_idx;
  logic                  kv_end;

  ////////////////////////////////////////////////////////////
  // Key-vault intercept
  ////////////////////////////////////////////////////////////

  kv_intercept_ctrl #(
    .NumChunks (NumChunks)
  ) u_intercept (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_in_we_i  (data_in_we_i),
    .core_idle_i   (core_idle_i),
    .core_valid_i  (core_out_i.valid),
    .kv_ctrl_i     (kv_ctrl_i),
    .core_data_i   (core_out_i.data),
    .data_out_o    (data_out_o),
    .output_lost_o (output_lost_o),
    .capture_o     (kv_capture),
    .end_o         (kv_end),
    .capture_idx_o (kv_capture_idx)
  );

  // Block data goes straight from the core into the buffer
  kv_chunk_buffer #(
    .NumChunks (NumChunks)
  ) u_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .capture_i       (kv_capture),
    .end_i           (kv_end),
    .capture_idx_i   (kv_capture_idx),
    .block_i         (core_out_i.data),
    .kv_ctrl_i       (kv_ctrl_i),
    .kv_data_o       (kv_data_o),
    .kv_data_valid_o (kv_data_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // EDN
  ////////////////////////////////////////////////////////////

  edn_req_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clearing_req_i (clearing_req_i),
    .masking_req_i  (masking_req_i),
    .edn_ack_i      (edn_ack_i),
    .edn_req_o      (edn_req_o),
    .clearing_ack_o (clearing_ack_o),
    .masking_ack_o  (masking_ack_o)
  );

  // Both PRNGs see the same entropy word, only the winner gets an ack
  assign entropy_o = edn_bus_i;

endmodule

`default_nettype wire

/* design/edn_req_arbiter.sv */
////////////////////////////////////////////////////////////
// EDN request arbiter
// Merges the clearing and masking PRNG requests onto one
// EDN request, clearing PRNG first
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module edn_req_arbiter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clearing_req_i,
  input  logic masking_req_i,
  input  logic edn_ack_i,
  output logic edn_req_o,
  output logic clearing_ack_o,
  output logic masking_ack_o
);

  logic req_any;
  logic edn_req;
  logic hold_d;
  logic hold_q;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  assign req_any = clearing_req_i | masking_req_i;

  // Ack goes only to the winner
  assign clearing_ack_o = clearing_req_i & edn_ack_i;
  assign masking_ack_o  = ~clearing_req_i & masking_req_i & edn_ack_i;

  ////////////////////////////////////////////////////////////
  // Request hold
  ////////////////////////////////////////////////////////////

  // Once raised, the EDN request stays up until EDN acks it
  assign edn_req = req_any | hold_q;
  assign hold_d  = edn_req & ~edn_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= hold_d;
    end
  end

  assign edn_req_o = edn_req;

  // The two PRNGs never consume the same entropy word
  ack_onehot_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(clearing_ack_o && masking_ack_o)
  );

endmodule

`default_nettype wire

/* kv_intercept/kv_chunk_buffer.sv */
////////////////////////////////////////////////////////////
// Key-vault chunk buffer
// Collects output blocks into chunk slots and flags the
// assembled key as valid at the end of an operation
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module kv_chunk_buffer #(
  parameter int unsigned NumChunks = aes_kv_pkg::NumChunks
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        capture_i,
  input  logic                                        end_i,
  input  aes_kv_pkg::chunk_idx_t                      capture_idx_i,
  input  aes_kv_pkg::block_t                          block_i,
  input  aes_kv_pkg::kv_ctrl_t                        kv_ctrl_i,
  output logic [NumChunks*aes_kv_pkg::BlockWidth-1:0] kv_data_o,
  output logic                                        kv_data_valid_o
);

  aes_kv_pkg::block_t [NumChunks-1:0] chunk_q;
  logic                               valid_q;
  logic                               clear_now;
  logic                               done_clear;

  // Secrets and data-out clear win over everything
  assign clear_now  = kv_ctrl_i.clear_secrets || kv_ctrl_i.data_out_clear;
  // Write-done only clears when no new key completes
  assign done_clear = kv_ctrl_i.kv_write_done && !end_i;

  ////////////////////////////////////////////////////////////
  // Chunk slots
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumChunks; i++) begin : gen_chunk
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        chunk_q[i] <= '0;
      end else if (clear_now) begin
        chunk_q[i] <= '0;
      end else if (capture_i && (capture_idx_i == aes_kv_pkg::chunk_idx_t'(i))) begin
        chunk_q[i] <= block_i;
      end else if (done_clear) begin
        chunk_q[i] <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_now) begin
      valid_q <= 1'b0;
    end else if (end_i) begin
      valid_q <= 1'b1;
    end else if (done_clear) begin
      valid_q <= 1'b0;
    end
  end

  // Chunk 0 sits in the low bits
  assign kv_data_o       = chunk_q;
  assign kv_data_valid_o = valid_q;

  // A key never becomes visible right after a secrets wipe
  valid_after_clear_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    kv_ctrl_i.clear_secrets |=> !kv_data_valid_o
  );

endmodule

`default_nettype wire

/* kv_intercept/kv_intercept_ctrl.sv */
////////////////////////////////////////////////////////////
// Key-vault intercept control
// Arms on the first data-in write, counts output beats,
// detects end of operation and conceals data-out
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module kv_intercept_ctrl #(
  parameter int unsigned NumChunks = aes_kv_pkg::NumChunks
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_in_we_i,
  input  logic                   core_idle_i,
  input  logic                   core_valid_i,
  input  aes_kv_pkg::kv_ctrl_t   kv_ctrl_i,
  input  aes_kv_pkg::block_t     core_data_i,
  output aes_kv_pkg::block_t     data_out_o,
  output logic                   output_lost_o,
  output logic                   capture_o,
  output logic                   end_o,
  output aes_kv_pkg::chunk_idx_t capture_idx_o
);

  // One counter bit is kept even for a single-chunk buffer
  localparam int unsigned CntWidth   = (NumChunks > 1) ? $clog2(NumChunks) : 1;
  localparam int unsigned BlockBytes = aes_kv_pkg::BlockWidth / 8;

  logic                intercept_q;
  logic                mask_en_q;
  logic                output_lost_q;
  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] thresh;
  logic [6:0]          key_blocks;
  logic                arm;
  logic                capture;
  logic                intercept_end;

  ////////////////////////////////////////////////////////////
  // Threshold and strobes
  ////////////////////////////////////////////////////////////

  // Last chunk index for the key size, limited to the buffer depth
  always_comb begin
    key_blocks = kv_ctrl_i.key_size / 7'(BlockBytes);
    if (key_blocks == 7'd0) begin
      thresh = '0;
    end else if (key_blocks > 7'(NumChunks)) begin
      thresh = CntWidth'(NumChunks - 1);
    end else begin
      thresh = CntWidth'(key_blocks - 7'd1);
    end
  end

  // Firmware arms the intercept with its first data-in write
  assign arm           = data_in_we_i && (cnt_q == '0);
  assign capture       = intercept_q && core_valid_i;
  assign intercept_end = intercept_q && core_idle_i && (cnt_q == thresh);

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intercept_q <= 1'b0;
      mask_en_q   <= 1'b1;
    end else if (arm) begin
      intercept_q <= kv_ctrl_i.kv_en;
      mask_en_q   <= ~kv_ctrl_i.kv_en & ~kv_ctrl_i.block_reg_output;
    end else if (intercept_end) begin
      intercept_q <= 1'b0;
      mask_en_q   <= 1'b1;
    end
  end

  // Saturates at the threshold so extra beats overwrite the last chunk
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!intercept_q || intercept_end) begin
      cnt_q <= '0;
    end else if (capture && (cnt_q != thresh)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // A blocked beat is lost, a new operation starts clean
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      output_lost_q <= 1'b0;
    end else if (core_valid_i && kv_ctrl_i.block_reg_output) begin
      output_lost_q <= 1'b1;
    end else if (arm) begin
      output_lost_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign data_out_o    = mask_en_q ? core_data_i : '0;
  assign output_lost_o = output_lost_q;
  assign capture_o     = capture;
  assign end_o         = intercept_end;
  assign capture_idx_o = aes_kv_pkg::chunk_idx_t'(cnt_q);

  // Key size is held during an operation, so the count stays in range
  cnt_in_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    intercept_q |-> (cnt_q <= thresh)
  );

endmodule

`default_nettype wire

/* common/aes_kv_pkg.sv */
////////////////////////////////////////////////////////////
// AES key-vault intercept package
// Widths, chunk geometry and the structs shared by the
// intercept control, the chunk buffer and the top level
////////////////////////////////////////////////////////////

`default_nettype none

package aes_kv_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // One AES output block, four 32-bit data-out words
  parameter int unsigned BlockWidth = 128;

  // Key-vault write width
  parameter int unsigned KvWrWidth = 512;

  // Number of output blocks held by the key-vault buffer
  parameter int unsigned NumChunks = KvWrWidth / BlockWidth;

  // Width of a chunk index
  parameter int unsigned ChunkIdxWidth = 2;

  // EDN entropy bus width
  parameter int unsigned EntropyWidth = 32;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [BlockWidth-1:0] block_t;

  typedef logic [ChunkIdxWidth-1:0] chunk_idx_t;

  // Key size in bytes, legal values are 16, 32, 48 and 64
  typedef logic [6:0] key_size_t;

  // Output beat of the AES core
  typedef struct packed {
    // Single-cycle strobe marking a new output block
    logic   valid;
    block_t data;
  } core_out_t;

  // Key-vault control from the surrounding system
  typedef struct packed {
    // Route output blocks to the key vault
    logic      kv_en;
    // Forbid register read-out of output blocks
    logic      block_reg_output;
    key_size_t key_size;
    // Level, wipes the buffer while high
    logic      clear_secrets;
    // Strobe from the key-vault writer once the key is consumed
    logic      kv_write_done;
    // Strobe from the data-out clear trigger
    logic      data_out_clear;
  } kv_ctrl_t;

endpackage

`default_nettype wire
